// File: Makefile
# Verilator build and run of the dependency-tracking core testbench

VERILATOR ?= verilator
TOP       ?= tb_expipe_track
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_expipe_track.sv
/*
 * Testbench of the dependency-tracking core.
 * Directed tests drive issue, writeback, commit and flush, and check the DUT
 * against a reference model of writer counts, newest writers and the ROB order.
 */

`include "expipe_defines.svh"

module tb_expipe_track;

    localparam int REGS  = `EXPIPE_REG_NUM;
    localparam int DEPTH = `EXPIPE_ROB_DEPTH;
    localparam int LIMIT = 50; // cycles allowed per wait

    logic clk_i, rst_n_i, flush_i;
    logic issue_valid_i, issue_ready_o, issue_rs1_busy_o, issue_rs2_busy_o;
    logic wb_valid_i, comm_valid_o, comm_ready_i;
    expipe_pkg::reg_idx_t issue_rd_idx_i, issue_rs1_idx_i, issue_rs2_idx_i, comm_rd_idx_o;
    rob_pkg::rob_idx_t    issue_rob_idx_o, issue_rs1_rob_idx_o, issue_rs2_rob_idx_o;
    rob_pkg::rob_idx_t    wb_rob_idx_i, comm_rob_idx_o;
    expipe_pkg::data_t    wb_data_i, comm_data_o;

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    int                wr_cnt [REGS];     // in-flight writers per reg
    rob_pkg::rob_idx_t newest [REGS];     // youngest producer per reg
    rob_pkg::rob_idx_t tail_m;            // next ROB slot
    int                pend_rob [$];      // issued entries, program order
    int                pend_rd [$];
    expipe_pkg::data_t wb_data_m [DEPTH];
    bit                wb_done_m [DEPTH];

    expipe_track_top i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("Simulation FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check(input logic [31:0] act, input logic [31:0] exp, input string what);
        if (act !== exp) begin
            $display("Fail at %0t: %s, got %0h expected %0h", $time, what, act, exp);
            abort_run("a DUT output did not match the model");
        end
    endtask

    function automatic void model_clear();
        foreach (wr_cnt[r]) begin
            wr_cnt[r] = 0;
            newest[r] = '0;
        end
        pend_rob.delete();
        pend_rd.delete();
        tail_m = '0;
    endfunction

    function automatic void model_issue(input expipe_pkg::reg_idx_t rd);
        pend_rob.push_back(int'(tail_m));
        pend_rd.push_back(int'(rd));
        wb_done_m[tail_m] = 1'b0;
        if (rd != '0) begin // r0 never tracked
            wr_cnt[rd]++;
            newest[rd] = tail_m;
        end
        tail_m++; // wraps with the ROB
    endfunction

    function automatic void model_commit();
        int rd;
        rd = pend_rd.pop_front();
        void'(pend_rob.pop_front());
        if (rd != 0) wr_cnt[rd]--;
    endfunction

    // sampled at the falling edge, lookups show state before this cycle
    task automatic check_lookups(input expipe_pkg::reg_idx_t rs1, rs2);
        check(32'(issue_rs1_busy_o), 32'(wr_cnt[rs1] != 0), "rs1 busy");
        check(32'(issue_rs1_rob_idx_o), 32'(newest[rs1]), "rs1 producer");
        check(32'(issue_rs2_busy_o), 32'(wr_cnt[rs2] != 0), "rs2 busy");
        check(32'(issue_rs2_rob_idx_o), 32'(newest[rs2]), "rs2 producer");
    endtask

    task automatic lookup(input expipe_pkg::reg_idx_t rs1, rs2);
        @(posedge clk_i);
        issue_rs1_idx_i <= rs1;
        issue_rs2_idx_i <= rs2;
        @(negedge clk_i);
        check_lookups(rs1, rs2);
    endtask

    task automatic lookup_all();
        for (int r = 0; r < REGS; r++) begin
            lookup(expipe_pkg::reg_idx_t'(r), expipe_pkg::reg_idx_t'(REGS - 1 - r));
        end
    endtask

    task automatic issue(input expipe_pkg::reg_idx_t rd, rs1, rs2);
        int n;
        n = 0;
        @(posedge clk_i);
        issue_valid_i   <= 1'b1;
        issue_rd_idx_i  <= rd;
        issue_rs1_idx_i <= rs1;
        issue_rs2_idx_i <= rs2;
        @(negedge clk_i);
        while (!issue_ready_o) begin // ROB full, hold the request
            n++;
            if (n > LIMIT) abort_run("issue_ready_o stayed low, the issue was never accepted");
            @(negedge clk_i);
        end
        check(32'(issue_rob_idx_o), 32'(tail_m), "issue rob index");
        check_lookups(rs1, rs2);
        @(posedge clk_i); // accepted here
        issue_valid_i <= 1'b0;
        model_issue(rd);
    endtask

    task automatic writeback(input int idx);
        expipe_pkg::data_t d;
        d = $urandom;
        @(posedge clk_i);
        wb_valid_i   <= 1'b1;
        wb_rob_idx_i <= rob_pkg::rob_idx_t'(idx);
        wb_data_i    <= d;
        @(posedge clk_i);
        wb_valid_i <= 1'b0;
        wb_data_m[idx] = d;
        wb_done_m[idx] = 1'b1;
    endtask

    task automatic commit_one();
        int n;
        n = 0;
        @(posedge clk_i);
        comm_ready_i <= 1'b1;
        @(negedge clk_i);
        while (!comm_valid_o) begin
            n++;
            if (n > LIMIT) abort_run("comm_valid_o never rose, the head entry did not commit");
            @(negedge clk_i);
        end
        check(32'(comm_rob_idx_o), pend_rob[0], "commit rob index");
        check(32'(comm_rd_idx_o), pend_rd[0], "commit rd");
        check(comm_data_o, wb_data_m[pend_rob[0]], "commit data");
        @(posedge clk_i); // retires here
        comm_ready_i <= 1'b0;
        model_commit();
    endtask

    // issue and commit share one edge
    task automatic issue_commit_same(input expipe_pkg::reg_idx_t rd);
        @(posedge clk_i);
        issue_valid_i  <= 1'b1;
        issue_rd_idx_i <= rd;
        comm_ready_i   <= 1'b1;
        @(negedge clk_i);
        check(32'(comm_valid_o), 1, "commit valid in shared cycle");
        check(32'(comm_rob_idx_o), pend_rob[0], "commit index in shared cycle");
        check(32'(comm_rd_idx_o), pend_rd[0], "commit rd in shared cycle");
        check(32'(issue_ready_o), 1, "issue ready in shared cycle");
        check(32'(issue_rob_idx_o), 32'(tail_m), "issue index in shared cycle");
        @(posedge clk_i);
        issue_valid_i <= 1'b0;
        comm_ready_i  <= 1'b0;
        model_commit();
        model_issue(rd);
    endtask

    task automatic drain();
        foreach (pend_rob[i]) if (!wb_done_m[pend_rob[i]]) writeback(pend_rob[i]);
        while (pend_rob.size() > 0) commit_one();
    endtask

    task automatic flush_all();
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        model_clear();
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic reset_and_lookup();
        @(negedge clk_i);
        check(32'(issue_ready_o), 1, "ready after reset");
        check(32'(comm_valid_o), 0, "commit valid after reset");
        lookup_all();
        issue(0, 0, 0); // zero register as destination
        issue(5, 0, 0); // lands past entry 0
        lookup(5, 0);
        lookup(0, 5);
        drain();
    endtask

    task automatic ooo_writeback();
        int order [4];
        int j;
        int t;
        issue(1, 0, 0);
        issue(2, 1, 0);
        issue(3, 1, 2);
        issue(4, 3, 3);
        foreach (order[i]) order[i] = pend_rob[i];
        for (int i = 3; i > 0; i--) begin // shuffle the writeback order
            j = $urandom_range(i);
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        foreach (order[i]) writeback(order[i]);
        repeat (4) commit_one();
    endtask

    task automatic multi_writer();
        issue(7, 0, 0);
        issue(7, 7, 0);
        issue(7, 7, 7);
        lookup(7, 0);
        foreach (pend_rob[i]) writeback(pend_rob[i]);
        repeat (3) begin
            commit_one();
            lookup(7, 0); // busy until the last writer leaves
        end
        issue(7, 7, 0);
        writeback(pend_rob[0]);
        issue_commit_same(7);
        lookup(7, 0);
        drain();
        lookup(7, 0); // free again once the shared-cycle writer retires
    endtask

    task automatic full_and_backpressure();
        for (int i = 1; i <= DEPTH; i++) issue(expipe_pkg::reg_idx_t'(i), 0, 0);
        @(negedge clk_i);
        check(32'(issue_ready_o), 0, "ready with a full ROB");
        writeback(pend_rob[0]);
        repeat (4) begin // comm_ready_i low, head must hold
            @(negedge clk_i);
            check(32'(comm_valid_o), 1, "held commit valid");
            check(32'(comm_rob_idx_o), pend_rob[0], "held commit index");
            check(comm_data_o, wb_data_m[pend_rob[0]], "held commit data");
        end
        commit_one();
        @(negedge clk_i);
        check(32'(issue_ready_o), 1, "ready after one commit");
        drain();
    endtask

    task automatic flush_recovery();
        issue(9, 0, 0);
        issue(10, 9, 0);
        issue(11, 10, 9);
        writeback(pend_rob[0]);
        flush_all();
        @(negedge clk_i);
        check(32'(comm_valid_o), 0, "commit valid after flush");
        check(32'(issue_ready_o), 1, "ready after flush");
        lookup_all();
        issue(12, 9, 10); // lands in entry 0
        lookup(12, 0);
    endtask

    initial begin
        void'($urandom(32'h2908_2f06));
        rst_n_i         = 1'b0;
        flush_i         = 1'b0;
        issue_valid_i   = 1'b0;
        issue_rd_idx_i  = '0;
        issue_rs1_idx_i = '0;
        issue_rs2_idx_i = '0;
        wb_valid_i      = 1'b0;
        wb_rob_idx_i    = '0;
        wb_data_i       = '0;
        comm_ready_i    = 1'b0;
        model_clear();
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        reset_and_lookup();
        ooo_writeback();
        multi_writer();
        full_and_backpressure();
        flush_recovery();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: common/commit_if.sv
/*
 * Commit port of the ROB. The ROB drives the committing entry,
 * the consumer side returns ready. An entry retires in a cycle
 * where valid and ready are both high.
 */

interface commit_if;

    logic                  valid;   // head entry is valid and done
    expipe_pkg::reg_idx_t  rd_idx;  // destination being released
    rob_pkg::rob_idx_t     rob_idx; // head pointer
    expipe_pkg::data_t     data;    // value to write to the register file
    logic                  ready;   // consumer accepts the commit

    // ROB side
    modport src (
        output valid, rd_idx, rob_idx, data,
        input  ready
    );

    // status table and top side
    modport sink (
        input  valid, rd_idx, rob_idx, data,
        output ready
    );

endinterface

// File: common/expipe_defines.svh
/*
 * Compile-time sizes of the dependency-tracking core.
 * Included by the packages and by any RTL file that needs a depth.
 * Register count and ROB depth must be powers of two.
 */

`ifndef EXPIPE_DEFINES_SVH
`define EXPIPE_DEFINES_SVH

// architectural register file size, r0 hardwired
`define EXPIPE_REG_NUM 32

// reorder buffer entries
`define EXPIPE_ROB_DEPTH 8

// result word width
`define EXPIPE_XLEN 32

`endif

// File: common/expipe_pkg.sv
/*
 * Architectural types shared by the pipeline blocks.
 * Register indices and result words, sized from the defines header.
 * Referenced by scope as expipe_pkg::name.
 */

`include "expipe_defines.svh"

package expipe_pkg;

    // ------------------------------------------------------------
    // architectural register index
    // ------------------------------------------------------------
    // 5 bits for 32 registers, index 0 is the zero register
    typedef logic [$clog2(`EXPIPE_REG_NUM)-1:0] reg_idx_t;

    // ------------------------------------------------------------
    // data word
    // ------------------------------------------------------------
    // one result as produced by an execution unit
    typedef logic [`EXPIPE_XLEN-1:0] data_t;

endpackage

// File: common/rob_pkg.sv
/*
 * Reorder buffer types: entry index, occupancy count, stored entry.
 * The count type is one bit wider than the index so a full ROB
 * (and eight writers of one register) can be represented.
 */

`include "expipe_defines.svh"

package rob_pkg;

    typedef logic [$clog2(`EXPIPE_ROB_DEPTH)-1:0] rob_idx_t; // entry pointer
    typedef logic [$clog2(`EXPIPE_ROB_DEPTH):0]   rob_cnt_t; // 0 .. depth inclusive

    // one ROB slot
    typedef struct packed {
        logic                  valid;  // slot holds an in-flight instr
        logic                  done;   // result has been written back
        expipe_pkg::reg_idx_t  rd_idx; // destination register
        expipe_pkg::data_t     data;   // result value
    } rob_entry_t;

endpackage

// File: hw/expipe_track_top.sv
/*
 * Top level of the dependency-tracking core.
 * Joins the ROB and the register status table; every port is plain.
 */

module expipe_track_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,

    // ------------------------------------------------------------
    // issue
    // ------------------------------------------------------------
    input  logic                 issue_valid_i,
    input  expipe_pkg::reg_idx_t issue_rd_idx_i,
    input  expipe_pkg::reg_idx_t issue_rs1_idx_i,
    input  expipe_pkg::reg_idx_t issue_rs2_idx_i,
    output logic                 issue_ready_o,
    output rob_pkg::rob_idx_t    issue_rob_idx_o,
    output logic                 issue_rs1_busy_o,
    output rob_pkg::rob_idx_t    issue_rs1_rob_idx_o,
    output logic                 issue_rs2_busy_o,
    output rob_pkg::rob_idx_t    issue_rs2_rob_idx_o,

    // writeback
    input  logic                 wb_valid_i,
    input  rob_pkg::rob_idx_t    wb_rob_idx_i,
    input  expipe_pkg::data_t    wb_data_i,

    // commit
    output logic                 comm_valid_o,
    output expipe_pkg::reg_idx_t comm_rd_idx_o,
    output rob_pkg::rob_idx_t    comm_rob_idx_o,
    output expipe_pkg::data_t    comm_data_o,
    input  logic                 comm_ready_i
);

    logic issue_fire; // ROB accepted the issue

    commit_if u_comm ();

    assign u_comm.ready   = comm_ready_i;  // outside consumer back-pressure
    assign comm_valid_o   = u_comm.valid;
    assign comm_rd_idx_o  = u_comm.rd_idx;
    assign comm_rob_idx_o = u_comm.rob_idx;
    assign comm_data_o    = u_comm.data;

    reorder_buffer u_rob (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .issue_valid_i   (issue_valid_i),
        .issue_rd_idx_i  (issue_rd_idx_i),
        .issue_ready_o   (issue_ready_o),
        .issue_fire_o    (issue_fire),
        .issue_rob_idx_o (issue_rob_idx_o),
        .wb_valid_i      (wb_valid_i),
        .wb_rob_idx_i    (wb_rob_idx_i),
        .wb_data_i       (wb_data_i),
        .comm            (u_comm.src)
    );

    int_regstat u_regstat (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .flush_i             (flush_i),
        .issue_fire_i        (issue_fire),
        .issue_rd_idx_i      (issue_rd_idx_i),
        .issue_rob_idx_i     (issue_rob_idx_o), // tail before the edge
        .issue_rs1_idx_i     (issue_rs1_idx_i),
        .issue_rs2_idx_i     (issue_rs2_idx_i),
        .issue_rs1_busy_o    (issue_rs1_busy_o),
        .issue_rs2_busy_o    (issue_rs2_busy_o),
        .issue_rs1_rob_idx_o (issue_rs1_rob_idx_o),
        .issue_rs2_rob_idx_o (issue_rs2_rob_idx_o),
        .comm                (u_comm.sink)
    );

endmodule

// File: hw/regstat/int_regstat.sv
/*
 * Integer register status table.
 * One writer counter per register keeps it busy until the last
 * in-flight writer commits; a second table holds the newest ROB
 * writer. Two combinational lookup ports serve the issuing instr.
 */

`include "expipe_defines.svh"

module int_regstat (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,

    // issue side
    input  logic                 issue_fire_i,        // issue accepted this cycle
    input  expipe_pkg::reg_idx_t issue_rd_idx_i,      // destination of the issuing instr
    input  rob_pkg::rob_idx_t    issue_rob_idx_i,     // ROB tail it lands in
    input  expipe_pkg::reg_idx_t issue_rs1_idx_i,
    input  expipe_pkg::reg_idx_t issue_rs2_idx_i,
    output logic                 issue_rs1_busy_o,
    output logic                 issue_rs2_busy_o,
    output rob_pkg::rob_idx_t    issue_rs1_rob_idx_o, // producer of rs1
    output rob_pkg::rob_idx_t    issue_rs2_rob_idx_o, // producer of rs2

    commit_if.sink               comm                 // retiring entry
);

    localparam int unsigned REG_NUM = `EXPIPE_REG_NUM;

    rob_pkg::rob_cnt_t writer_cnt [REG_NUM];  // in-flight writers per reg
    rob_pkg::rob_idx_t newest_rob [REG_NUM];  // youngest producer per reg
    logic              comm_fire;
    logic              same_reg;              // issue and commit hit one reg
    logic              issue_inc;
    logic              comm_dec;

    // ------------------------------------------------------------
    // counter steering
    // ------------------------------------------------------------
    assign comm_fire = comm.valid & comm.ready;
    assign same_reg  = issue_fire_i & comm_fire & (issue_rd_idx_i == comm.rd_idx);
    assign issue_inc = issue_fire_i & (issue_rd_idx_i != '0) & ~same_reg;
    assign comm_dec  = comm_fire & (comm.rd_idx != '0) & ~same_reg; // +1 -1 cancels

    assign writer_cnt[0] = '0; // r0 is never busy

    for (genvar r = 1; r < REG_NUM; r++) begin : g_writer_cnt
        logic inc; // one more writer of r
        logic dec; // one writer of r retires

        assign inc = issue_inc & (issue_rd_idx_i == r);
        assign dec = comm_dec & (comm.rd_idx == r);

        updown_counter #(
            .W ($bits(rob_pkg::rob_cnt_t))
        ) u_writer_cnt (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .en_i    (inc | dec),
            .clr_i   (flush_i),
            .up_dn_i (inc),
            .count_o (writer_cnt[r])
        );
    end

    // ------------------------------------------------------------
    // newest writer table
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin : newest_upd
        if (!rst_n_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                newest_rob[i] <= '0;
            end
        end else if (flush_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                newest_rob[i] <= '0;
            end
        end else if (issue_fire_i && issue_rd_idx_i != '0) begin
            newest_rob[issue_rd_idx_i] <= issue_rob_idx_i; // also on same_reg
        end
    end

    // lookups see state before this cycle's issue and commit
    assign issue_rs1_busy_o    = |writer_cnt[issue_rs1_idx_i];
    assign issue_rs1_rob_idx_o = newest_rob[issue_rs1_idx_i];
    assign issue_rs2_busy_o    = |writer_cnt[issue_rs2_idx_i];
    assign issue_rs2_rob_idx_o = newest_rob[issue_rs2_idx_i];

    // a retiring writer must have been counted at issue
    a_comm_counted : assert property (
        @(posedge clk_i) disable iff (!rst_n_i || flush_i)
        (comm_fire && comm.rd_idx != '0) |-> (writer_cnt[comm.rd_idx] != '0)
    );

endmodule

// File: hw/rob/reorder_buffer.sv
/*
 * Circular reorder buffer.
 * Allocates at the tail on issue, takes results in any order on
 * writeback and offers the head entry for commit once it is done.
 * Flush drops every in-flight entry in one cycle.
 */

`include "expipe_defines.svh"

module reorder_buffer (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,

    // issue
    input  logic                 issue_valid_i,
    input  expipe_pkg::reg_idx_t issue_rd_idx_i,
    output logic                 issue_ready_o,   // not full
    output logic                 issue_fire_o,    // valid & ready
    output rob_pkg::rob_idx_t    issue_rob_idx_o, // current tail

    // writeback, valid only
    input  logic                 wb_valid_i,
    input  rob_pkg::rob_idx_t    wb_rob_idx_i,
    input  expipe_pkg::data_t    wb_data_i,

    commit_if.src                comm
);

    localparam int unsigned       DEPTH    = `EXPIPE_ROB_DEPTH;
    localparam rob_pkg::rob_cnt_t FULL_CNT = rob_pkg::rob_cnt_t'(DEPTH);

    rob_pkg::rob_entry_t entries [DEPTH];
    rob_pkg::rob_idx_t   head_q;  // oldest entry
    rob_pkg::rob_idx_t   tail_q;  // next free slot
    rob_pkg::rob_cnt_t   count_q; // occupancy
    logic                comm_fire;

    // ------------------------------------------------------------
    // handshakes
    // ------------------------------------------------------------
    assign issue_ready_o   = (count_q != FULL_CNT);
    assign issue_fire_o    = issue_valid_i & issue_ready_o;
    assign issue_rob_idx_o = tail_q;

    // head entry straight to the commit port
    assign comm.valid   = entries[head_q].valid & entries[head_q].done;
    assign comm.rd_idx  = entries[head_q].rd_idx;
    assign comm.rob_idx = head_q;
    assign comm.data    = entries[head_q].data;
    assign comm_fire    = comm.valid & comm.ready;

    // ------------------------------------------------------------
    // pointers and count
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin : ptr_upd
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (issue_fire_o) tail_q <= tail_q + 1'b1; // wraps at depth
            if (comm_fire)    head_q <= head_q + 1'b1;
            case ({issue_fire_o, comm_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;        // none, or both
            endcase
        end
    end

    // ------------------------------------------------------------
    // entry array
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin : entry_upd
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (flush_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].valid <= 1'b0; // payload left stale
            end
        end else begin
            if (issue_fire_o) begin
                entries[tail_q].valid  <= 1'b1;
                entries[tail_q].done   <= 1'b0;
                entries[tail_q].rd_idx <= issue_rd_idx_i;
            end
            if (wb_valid_i) begin
                entries[wb_rob_idx_i].done <= 1'b1;
                entries[wb_rob_idx_i].data <= wb_data_i;
            end
            if (comm_fire) entries[head_q].valid <= 1'b0; // slot free again
        end
    end

    // writeback must name an in-flight entry that is still waiting
    a_wb_target : assert property (
        @(posedge clk_i) disable iff (!rst_n_i || flush_i)
        wb_valid_i |-> (entries[wb_rob_idx_i].valid && !entries[wb_rob_idx_i].done)
    );

    a_count_max : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        count_q <= FULL_CNT
    );

endmodule

// File: hw/updown_counter.sv
/*
 * Up/down counter with enable and synchronous clear.
 * No saturation: the user keeps the count inside its range.
 * Clear wins over counting.
 */

module updown_counter #(
    parameter int unsigned W = 4 // counter width
) (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         en_i,    // count this cycle
    input  logic         clr_i,   // back to zero, priority over en_i
    input  logic         up_dn_i, // 1 up, 0 down
    output logic [W-1:0] count_o
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin : cnt_reg
        if (!rst_n_i) begin
            count_o <= '0;
        end else if (clr_i) begin
            count_o <= '0;
        end else if (en_i) begin
            if (up_dn_i) begin
                count_o <= count_o + 1'b1;
            end else begin
                count_o <= count_o - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    // a decrement from zero means the caller lost track of a writer
    a_no_underflow : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (en_i && !clr_i && !up_dn_i) |-> (count_o != '0)
    );

endmodule

// File: tb.f
+incdir+common
common/expipe_pkg.sv
common/rob_pkg.sv
common/commit_if.sv
hw/updown_counter.sv
hw/regstat/int_regstat.sv
hw/rob/reorder_buffer.sv
hw/expipe_track_top.sv
bench/tb_expipe_track.sv
